// File: rtl/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// io register map
`define DMA_REG_ADDR  16'hFF46   // oam dma source page
`define HDMA1_ADDR    16'hFF51   // gdma source high
`define HDMA2_ADDR    16'hFF52   // gdma source low
`define HDMA3_ADDR    16'hFF53   // gdma destination high
`define HDMA4_ADDR    16'hFF54   // gdma destination low
`define HDMA5_ADDR    16'hFF55   // gdma length, start and status

// sprite attribute table
`define OAM_PAGE      8'hFE      // oam sits at FE00
`define OAM_LEN       8'd160     // bytes per oam copy

// vram destination forced into 8000-9FFF
`define VRAM_PREFIX   3'b100

// gdma length unit, bytes per block
`define BLOCK_BYTES   16

`endif

// File: rtl/dma_pkg.sv
`default_nettype none

package dma_pkg;

   // memory map address, register or memory
   typedef logic [15:0] addr_t;

   // one byte on the register bus or memory ports
   typedef logic [7:0] byte_t;

   // gdma byte count, up to 128 blocks of 16
   typedef logic [11:0] xfer_len_t;

   typedef enum logic {
      OAM_IDLE,   // waiting for a write to DMA
      OAM_COPY    // one byte per cycle
   } oam_state_e;

   typedef enum logic {
      GDMA_IDLE,  // waiting for a write to HDMA5
      GDMA_COPY   // moving bytes when granted
   } gdma_state_e;

endpackage

`default_nettype wire

// File: rtl/dma_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one engine's request for the shared memory ports
interface dma_req_if
   import dma_pkg::*;
();

   logic  req;        // engine wants a byte moved this cycle
   logic  grant;      // arbiter owns the ports for this engine
   addr_t src_addr;   // read side address
   addr_t dst_addr;   // write side address

   modport engine (
      output req, src_addr, dst_addr,
      input  grant
   );

   modport arbiter (
      input  req, src_addr, dst_addr,
      output grant
   );

endinterface

`default_nettype wire

// File: rtl/dma_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_io_regs
   import dma_pkg::*;
(
   input  wire logic  I_CLK,
   input  wire logic  I_SYNC_RESET,

   input  wire addr_t ioreg_addr,
   input  wire byte_t ioreg_wdata,
   input  wire logic  ioreg_we_l,
   input  wire logic  ioreg_re_l,
   output byte_t      ioreg_rdata,

   input  wire logic  gdma_busy,

   output byte_t      oam_page,
   output byte_t      hdma_src_hi,
   output byte_t      hdma_src_lo,
   output byte_t      hdma_dst_hi,
   output byte_t      hdma_dst_lo,
   output byte_t      hdma_ctrl,
   output logic       oam_start,
   output logic       gdma_start
);

   logic reg_wr;

   assign reg_wr = ~ioreg_we_l;   // active low write strobe

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         oam_page    <= '0;
         hdma_src_hi <= '0;
         hdma_src_lo <= '0;
         hdma_dst_hi <= '0;
         hdma_dst_lo <= '0;
         hdma_ctrl   <= '0;
         oam_start   <= 1'b0;
         gdma_start  <= 1'b0;
      end else begin
         oam_start  <= reg_wr && (ioreg_addr == `DMA_REG_ADDR);
         // bit 7 set would select hblank mode, which starts nothing
         gdma_start <= reg_wr && (ioreg_addr == `HDMA5_ADDR) && !ioreg_wdata[7];
         if (reg_wr) begin
            case (ioreg_addr)
               `DMA_REG_ADDR: oam_page    <= ioreg_wdata;
               `HDMA1_ADDR:   hdma_src_hi <= ioreg_wdata;
               `HDMA2_ADDR:   hdma_src_lo <= ioreg_wdata;
               `HDMA3_ADDR:   hdma_dst_hi <= ioreg_wdata;
               `HDMA4_ADDR:   hdma_dst_lo <= ioreg_wdata;
               `HDMA5_ADDR:   hdma_ctrl   <= ioreg_wdata;
               default: ;                      // not ours
            endcase
         end
      end
   end

   always_comb begin
      ioreg_rdata = '0;
      if (!ioreg_re_l) begin
         case (ioreg_addr)
            `DMA_REG_ADDR: ioreg_rdata = oam_page;
            `HDMA1_ADDR:   ioreg_rdata = hdma_src_hi;
            `HDMA2_ADDR:   ioreg_rdata = hdma_src_lo;
            `HDMA3_ADDR:   ioreg_rdata = hdma_dst_hi;
            `HDMA4_ADDR:   ioreg_rdata = hdma_dst_lo;
            `HDMA5_ADDR:   ioreg_rdata = {gdma_busy, 7'd0};   // status only
            default:       ioreg_rdata = '0;
         endcase
      end
   end

   // a start reaches its engine as a single cycle strobe
   a_oam_start_pulse : assert property (
      @(posedge I_CLK) disable iff (I_SYNC_RESET) oam_start |=> !oam_start)
      else $error("oam_start held for more than one cycle");

   a_gdma_start_pulse : assert property (
      @(posedge I_CLK) disable iff (I_SYNC_RESET) gdma_start |=> !gdma_start)
      else $error("gdma_start held for more than one cycle");

endmodule

`default_nettype wire

// File: rtl/oam_dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module oam_dma_engine
   import dma_pkg::*;
(
   input  wire logic  I_CLK,
   input  wire logic  I_SYNC_RESET,

   input  wire logic  oam_start,
   input  wire byte_t oam_page,

   dma_req_if.engine  req
);

   oam_state_e state;
   logic [7:0] idx;       // byte offset within both pages
   byte_t      page_q;    // source page held for the whole copy

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state <= OAM_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            OAM_IDLE: begin
               if (oam_start) begin
                  state <= OAM_COPY;
                  idx   <= '0;
               end
            end
            OAM_COPY: begin
               if (req.grant) begin
                  if (idx == `OAM_LEN - 8'd1) begin
                     state <= OAM_IDLE;   // last byte moved
                     idx   <= '0;
                  end else begin
                     idx <= idx + 8'd1;
                  end
               end
            end
            default: state <= OAM_IDLE;
         endcase
      end
   end

   always_ff @(posedge I_CLK) begin
      if (state == OAM_IDLE && oam_start) begin
         page_q <= oam_page;
      end
   end

   assign req.req      = (state == OAM_COPY);
   assign req.src_addr = {page_q, idx};
   assign req.dst_addr = {`OAM_PAGE, idx};

   // oam copy must be exactly 160 back to back cycles
   a_oam_always_granted : assert property (
      @(posedge I_CLK) disable iff (I_SYNC_RESET)
      req.req |-> (req.grant && idx < `OAM_LEN))
      else $error("oam request not granted or index out of range");

endmodule

`default_nettype wire

// File: rtl/gdma_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module gdma_engine
   import dma_pkg::*;
(
   input  wire logic  I_CLK,
   input  wire logic  I_SYNC_RESET,

   input  wire logic  gdma_start,
   input  wire byte_t hdma_src_hi,
   input  wire byte_t hdma_src_lo,
   input  wire byte_t hdma_dst_hi,
   input  wire byte_t hdma_dst_lo,
   input  wire byte_t hdma_ctrl,

   dma_req_if.engine  req,
   output logic       gdma_busy
);

   gdma_state_e state;
   xfer_len_t   idx;
   addr_t       src_base;
   addr_t       dst_base;
   xfer_len_t   xfer_len;
   addr_t       src_base_q;
   addr_t       dst_base_q;
   xfer_len_t   len_q;

   // block aligned source, anywhere in the map
   assign src_base = {hdma_src_hi, hdma_src_lo[7:4], 4'h0};
   // block aligned destination inside vram
   assign dst_base = {`VRAM_PREFIX, hdma_dst_hi[4:0], hdma_dst_lo[7:4], 4'h0};
   assign xfer_len = (xfer_len_t'(hdma_ctrl[6:0]) + 12'd1) * xfer_len_t'(`BLOCK_BYTES);

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state <= GDMA_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            GDMA_IDLE: begin
               if (gdma_start) begin
                  state <= GDMA_COPY;
                  idx   <= '0;
               end
            end
            GDMA_COPY: begin
               if (req.grant) begin             // hold while oam owns the ports
                  if (idx == len_q - 12'd1) begin
                     state <= GDMA_IDLE;
                     idx   <= '0;
                  end else begin
                     idx <= idx + 12'd1;
                  end
               end
            end
            default: state <= GDMA_IDLE;
         endcase
      end
   end

   // snapshot so register writes mid copy do not move it
   always_ff @(posedge I_CLK) begin
      if (state == GDMA_IDLE && gdma_start) begin
         src_base_q <= src_base;
         dst_base_q <= dst_base;
         len_q      <= xfer_len;
      end
   end

   assign gdma_busy    = (state == GDMA_COPY);
   assign req.req      = gdma_busy;
   assign req.src_addr = src_base_q + addr_t'(idx);
   assign req.dst_addr = dst_base_q + addr_t'(idx);

   a_gdma_idx_in_range : assert property (
      @(posedge I_CLK) disable iff (I_SYNC_RESET) gdma_busy |-> (idx < len_q))
      else $error("gdma index reached the transfer length");

endmodule

`default_nettype wire

// File: rtl/dma_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dma_port_arbiter
   import dma_pkg::*;
(
   dma_req_if.arbiter oam,
   dma_req_if.arbiter gdma,

   output addr_t      rdma_addr,
   output addr_t      wdma_addr,
   input  wire byte_t rdma_data,
   output byte_t      wdma_data,
   output logic       rdma_re_l,
   output logic       wdma_we_l
);

   assign oam.grant  = oam.req;                // oam never waits
   assign gdma.grant = gdma.req && !oam.req;   // gdma stalls behind oam

   always_comb begin
      if (oam.grant) begin
         rdma_addr = oam.src_addr;
         wdma_addr = oam.dst_addr;
      end else if (gdma.grant) begin
         rdma_addr = gdma.src_addr;
         wdma_addr = gdma.dst_addr;
      end else begin
         rdma_addr = '0;
         wdma_addr = '0;
      end
   end

   // zero latency memory, read byte goes straight to the write port
   assign wdma_data = rdma_data;
   assign rdma_re_l = ~(oam.grant | gdma.grant);
   assign wdma_we_l = ~(oam.grant | gdma.grant);

   always_comb begin
      a_grant_onehot : assert (!(oam.grant && gdma.grant))
         else $error("both engines granted the memory ports");
   end

endmodule

`default_nettype wire

// File: rtl/dma_controller.sv
`timescale 1ns/1ps
`default_nettype none

module dma_controller
   import dma_pkg::*;
(
   input  wire logic  I_CLK,
   input  wire logic  I_SYNC_RESET,

   input  wire addr_t ioreg_addr,
   input  wire byte_t ioreg_wdata,
   output byte_t      ioreg_rdata,
   input  wire logic  ioreg_we_l,
   input  wire logic  ioreg_re_l,

   output addr_t      rdma_addr,
   input  wire byte_t rdma_data,
   output logic       rdma_re_l,

   output addr_t      wdma_addr,
   output byte_t      wdma_data,
   output logic       wdma_we_l
);

   byte_t oam_page;
   byte_t hdma_src_hi;
   byte_t hdma_src_lo;
   byte_t hdma_dst_hi;
   byte_t hdma_dst_lo;
   byte_t hdma_ctrl;
   logic  oam_start;
   logic  gdma_start;
   logic  gdma_busy;

   dma_req_if oam_req ();
   dma_req_if gdma_req ();

   dma_io_regs regs_i (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .ioreg_addr   (ioreg_addr),
      .ioreg_wdata  (ioreg_wdata),
      .ioreg_we_l   (ioreg_we_l),
      .ioreg_re_l   (ioreg_re_l),
      .ioreg_rdata  (ioreg_rdata),
      .gdma_busy    (gdma_busy),
      .oam_page     (oam_page),
      .hdma_src_hi  (hdma_src_hi),
      .hdma_src_lo  (hdma_src_lo),
      .hdma_dst_hi  (hdma_dst_hi),
      .hdma_dst_lo  (hdma_dst_lo),
      .hdma_ctrl    (hdma_ctrl),
      .oam_start    (oam_start),
      .gdma_start   (gdma_start)
   );

   oam_dma_engine oam_i (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .oam_start    (oam_start),
      .oam_page     (oam_page),
      .req          (oam_req.engine)
   );

   gdma_engine gdma_i (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .gdma_start   (gdma_start),
      .hdma_src_hi  (hdma_src_hi),
      .hdma_src_lo  (hdma_src_lo),
      .hdma_dst_hi  (hdma_dst_hi),
      .hdma_dst_lo  (hdma_dst_lo),
      .hdma_ctrl    (hdma_ctrl),
      .req          (gdma_req.engine),
      .gdma_busy    (gdma_busy)
   );

   dma_port_arbiter arb_i (
      .oam          (oam_req.arbiter),
      .gdma         (gdma_req.arbiter),
      .rdma_addr    (rdma_addr),
      .wdma_addr    (wdma_addr),
      .rdma_data    (rdma_data),
      .wdma_data    (wdma_data),
      .rdma_re_l    (rdma_re_l),
      .wdma_we_l    (wdma_we_l)
   );

endmodule

`default_nettype wire

// File: tests/dma_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_controller_tb
   import dma_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 6000;   // covers both copies and the overlap run with margin
   localparam int OAM_BYTES      = int'(`OAM_LEN);

   logic  I_CLK;
   logic  I_SYNC_RESET;
   addr_t ioreg_addr;
   byte_t ioreg_wdata;
   byte_t ioreg_rdata;
   logic  ioreg_we_l;
   logic  ioreg_re_l;
   addr_t rdma_addr;
   byte_t rdma_data;
   logic  rdma_re_l;
   addr_t wdma_addr;
   byte_t wdma_data;
   logic  wdma_we_l;

   byte_t mem [0:65535];        // full 64 KiB map
   int    err_count = 0;
   int    oam_cnt = 0;          // oam bytes seen on the ports over all copies
   int    oam_target = 0;       // oam bytes requested so far
   byte_t oam_src_page;
   int    gdma_cnt = 0;         // gdma bytes seen on the ports over all copies
   int    gdma_target = 0;
   int    gdma_first = 0;       // gdma_cnt value when the current copy began
   addr_t gdma_src;
   addr_t gdma_dst;

   always #5 I_CLK = ~I_CLK;

   dma_controller dut_i (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .ioreg_addr   (ioreg_addr),
      .ioreg_wdata  (ioreg_wdata),
      .ioreg_rdata  (ioreg_rdata),
      .ioreg_we_l   (ioreg_we_l),
      .ioreg_re_l   (ioreg_re_l),
      .rdma_addr    (rdma_addr),
      .rdma_data    (rdma_data),
      .rdma_re_l    (rdma_re_l),
      .wdma_addr    (wdma_addr),
      .wdma_data    (wdma_data),
      .wdma_we_l    (wdma_we_l)
   );

   assign rdma_data = mem[rdma_addr];   // zero latency read

   always @(posedge I_CLK) begin
      if (!wdma_we_l) begin
         mem[wdma_addr] <= wdma_data;
      end
   end

   task automatic report_error(input string msg);
      err_count++;
      $display("** Error @ %0t: %s", $time, msg);
   endtask

   a_data_follows : assert property (@(posedge I_CLK) wdma_data == rdma_data)
      else report_error("write data differs from read data");
   a_strobes_paired : assert property (@(posedge I_CLK) rdma_re_l == wdma_we_l)
      else report_error("read and write strobes differ");
   a_quiet_in_reset : assert property (@(posedge I_CLK)
      (I_SYNC_RESET && $past(I_SYNC_RESET)) |-> (rdma_re_l && wdma_we_l))
      else report_error("memory strobe active during reset");
   a_rdata_idle : assert property (@(posedge I_CLK) ioreg_re_l |-> (ioreg_rdata == 8'h00))
      else report_error("register read data nonzero without a read");

   // every strobe cycle is classified by its destination page
   always @(negedge I_CLK) begin : transfer_monitor
      logic  is_oam;
      addr_t off;
      is_oam = !rdma_re_l && (wdma_addr[15:8] == `OAM_PAGE);
      if ((oam_cnt % OAM_BYTES) != 0 && oam_cnt < oam_target) begin
         a_oam_back_to_back : assert (is_oam)
            else report_error("OAM copy interrupted before 160 bytes");
      end
      if (is_oam) begin
         off = addr_t'(oam_cnt % OAM_BYTES);
         a_oam_expected : assert (oam_cnt < oam_target)
            else report_error("OAM transfer with no copy pending");
         a_oam_src : assert (rdma_addr == ({oam_src_page, 8'h00} + off))
            else report_error($sformatf("OAM read address %h, offset %h", rdma_addr, off));
         a_oam_dst : assert (wdma_addr == ({`OAM_PAGE, 8'h00} + off))
            else report_error($sformatf("OAM write address %h, offset %h", wdma_addr, off));
         oam_cnt++;
      end else if (!rdma_re_l) begin
         off = addr_t'(gdma_cnt - gdma_first);
         a_gdma_expected : assert (gdma_cnt < gdma_target)
            else report_error("GDMA transfer with no copy pending");
         a_gdma_src : assert (rdma_addr == gdma_src + off)
            else report_error($sformatf("GDMA read address %h, expected %h", rdma_addr,
                                        gdma_src + off));
         a_gdma_dst : assert (wdma_addr == gdma_dst + off)
            else report_error($sformatf("GDMA write address %h, expected %h", wdma_addr,
                                        gdma_dst + off));
         gdma_cnt++;
      end
   end

   task automatic write_reg(input addr_t addr, input byte_t data);
      @(posedge I_CLK);
      #1;
      ioreg_addr  = addr;
      ioreg_wdata = data;
      ioreg_we_l  = 1'b0;
      @(posedge I_CLK);
      #1;
      ioreg_we_l  = 1'b1;
   endtask

   task automatic read_reg(input addr_t addr, output byte_t data);
      @(posedge I_CLK);
      #1;
      ioreg_addr = addr;
      ioreg_re_l = 1'b0;
      @(negedge I_CLK);
      data = ioreg_rdata;   // combinational read is stable mid cycle
      @(posedge I_CLK);
      #1;
      ioreg_re_l = 1'b1;
   endtask

   task automatic check_reg(input addr_t addr, input byte_t expected);
      byte_t value;
      read_reg(addr, value);
      a_reg_value : assert (value == expected)
         else report_error($sformatf("register %h read %h, expected %h", addr, value, expected));
   endtask

   task automatic start_oam(input byte_t page);
      oam_src_page = page;
      oam_target   = oam_target + OAM_BYTES;
      write_reg(`DMA_REG_ADDR, page);
   endtask

   task automatic check_oam_copy();
      int i;
      wait (oam_cnt == oam_target);
      @(posedge I_CLK);   // last byte lands here
      #1;
      for (i = 0; i < OAM_BYTES; i++) begin
         a_oam_data : assert (mem[{`OAM_PAGE, 8'(i)}] == mem[{oam_src_page, 8'(i)}])
            else report_error($sformatf("OAM byte %0d wrong after copy", i));
      end
   endtask

   // block aligned bases with the vram prefix on the destination
   task automatic start_gdma(input byte_t src_hi, input byte_t src_lo, input byte_t dst_hi,
                             input byte_t dst_lo, input byte_t blocks_m1);
      gdma_src    = {src_hi, src_lo & 8'hF0};
      gdma_dst    = {`VRAM_PREFIX, dst_hi[4:0], dst_lo & 8'hF0};
      gdma_first  = gdma_target;
      gdma_target = gdma_target + `BLOCK_BYTES * (int'(blocks_m1[6:0]) + 1);
      write_reg(`HDMA1_ADDR, src_hi);
      write_reg(`HDMA2_ADDR, src_lo);
      write_reg(`HDMA3_ADDR, dst_hi);
      write_reg(`HDMA4_ADDR, dst_lo);
      write_reg(`HDMA5_ADDR, {1'b0, blocks_m1[6:0]});
   endtask

   task automatic finish_gdma_copy();
      byte_t status;
      int    i;
      status = 8'h80;
      while (status[7]) begin
         read_reg(`HDMA5_ADDR, status);   // busy flag polling
      end
      @(posedge I_CLK);
      #1;
      a_gdma_count : assert (gdma_cnt == gdma_target)
         else report_error($sformatf("GDMA moved %0d bytes, expected %0d", gdma_cnt, gdma_target));
      for (i = 0; i < gdma_target - gdma_first; i++) begin
         a_gdma_data : assert (mem[gdma_dst + addr_t'(i)] == mem[gdma_src + addr_t'(i)])
            else report_error($sformatf("GDMA byte %0d wrong after copy", i));
      end
   endtask

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge I_CLK);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   initial begin : stimulus
      int a;
      int quiet_before;
      I_CLK        = 1'b0;
      I_SYNC_RESET = 1'b1;
      ioreg_addr   = '0;
      ioreg_wdata  = '0;
      ioreg_we_l   = 1'b1;
      ioreg_re_l   = 1'b1;
      void'($urandom(32'ha5f8_e336));
      for (a = 0; a < 65536; a++) begin
         mem[addr_t'(a)] <= byte_t'($urandom) ^ byte_t'(a) ^ byte_t'(a >> 8);
      end
      repeat (4) @(posedge I_CLK);
      #1;
      I_SYNC_RESET = 1'b0;

      check_reg(`DMA_REG_ADDR, 8'h00);   // all registers clear after reset
      check_reg(`HDMA1_ADDR, 8'h00);
      check_reg(`HDMA2_ADDR, 8'h00);
      check_reg(`HDMA3_ADDR, 8'h00);
      check_reg(`HDMA4_ADDR, 8'h00);
      check_reg(`HDMA5_ADDR, 8'h00);

      start_oam(8'hC1);
      check_oam_copy();
      check_reg(`DMA_REG_ADDR, 8'hC1);

      start_gdma(8'hC3, 8'h5A, 8'hE9, 8'h7D, 8'h06);   // C350 to 8970 for 112 bytes
      check_reg(`HDMA5_ADDR, 8'h80);
      finish_gdma_copy();
      check_reg(`HDMA1_ADDR, 8'hC3);
      check_reg(`HDMA2_ADDR, 8'h5A);
      check_reg(`HDMA3_ADDR, 8'hE9);
      check_reg(`HDMA4_ADDR, 8'h7D);
      check_reg(`HDMA5_ADDR, 8'h00);
      check_reg(16'hFF50, 8'h00);
      check_reg(16'hFF56, 8'h00);

      // hblank mode starts nothing
      quiet_before = oam_cnt + gdma_cnt;
      write_reg(`HDMA5_ADDR, 8'h85);
      repeat (50) @(posedge I_CLK);
      a_hblank_quiet : assert (oam_cnt + gdma_cnt == quiet_before)
         else report_error("transfer after HDMA5 write with bit 7 set");
      check_reg(`HDMA5_ADDR, 8'h00);

      start_gdma(8'h21, 8'h8F, 8'hF2, 8'h3B, 8'h1F);   // 2180 to 9230 for 512 bytes
      wait (gdma_cnt >= gdma_first + 40);
      start_oam(8'h47);
      check_oam_copy();
      finish_gdma_copy();

      a_total_moved : assert (oam_cnt + gdma_cnt == 2 * OAM_BYTES + 112 + 512)
         else report_error($sformatf("%0d bytes moved in total", oam_cnt + gdma_cnt));
      $display("errors: %0d, oam bytes: %0d, gdma bytes: %0d", err_count, oam_cnt, gdma_cnt);
      if (err_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dma_controller.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_req_if.sv
rtl/dma_io_regs.sv
rtl/oam_dma_engine.sv
rtl/gdma_engine.sv
rtl/dma_port_arbiter.sv
rtl/dma_controller.sv
tests/dma_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the DMA controller testbench with Verilator, run it, and scan the log.
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
   --top-module dma_controller_tb -f dma_controller.f \
   --Mdir "$BUILD_DIR" -o sim_dma > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/sim_dma" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '\*\* FAIL \*\*' "$SIM_LOG"; then
   exit 1
fi
exit 0
